// ==== cc_subsys.f ====
cc_pkg.sv
req_fifo.sv
dcqcn_rate_ctrl.sv
cc_queue.sv
tx_arbiter.sv
cc_top.sv
tb_cc_top.sv

// ==== Bender.yml ====
package:
  name: cc_subsys

dependencies: {}

sources:
  - cc_pkg.sv
  - req_fifo.sv
  - dcqcn_rate_ctrl.sv
  - cc_queue.sv
  - tx_arbiter.sv
  - cc_top.sv
  - target: test
    files:
      - tb_cc_top.sv

// ==== tb_cc_top.sv ====
`timescale 1ns/10ps

module tb_cc_top;
    import cc_pkg::*;

    localparam int DEPTH        = 8;
    localparam int RC_DEFAULT   = 40;
    localparam int RT_DEFAULT   = 20;
    localparam int R_MIN        = 8;
    localparam int R_CAP        = 4096;
    localparam int MARK_HOLDOFF = 50;
    localparam int SA_RECOVER   = 2000;
    localparam int TIME_THRESH  = 1000;
    localparam int PKT_THRESH   = 8;
    localparam int F_STEPS      = 3;
    localparam int R_AI         = 4;
    localparam int R_HAI        = 8;

    // descriptors sent over all phases, and the quiet time that lets both rates settle
    localparam int N_DESC      = 46;
    localparam int SETTLE      = 300;
    localparam int GAP_OFF     = 0;
    localparam int GAP_EXACT   = 1;
    localparam int GAP_FALLING = 2;

    logic            aclk;
    logic            aresetn;
    logic [N_CH-1:0] s_req_valid;
    logic [N_CH-1:0] s_req_ready;
    req_t [N_CH-1:0] s_req_data;
    logic [N_CH-1:0] ecn_valid;
    logic [N_CH-1:0] ecn_mark;
    logic            m_req_valid;
    logic            m_req_ready;
    req_t            m_req_data;
    ch_id_t          m_req_ch;

    integer seed   = 20;
    int     errors = 0;
    int     cyc    = 0;
    req_t   exp_q [N_CH][$];
    int     beat_cnt [N_CH];
    int     last_cyc [N_CH];
    logic   last_valid [N_CH];
    int     gap_mode [N_CH];
    rate_t  exp_gap [N_CH];
    rate_t  prev_gap [N_CH];
    logic   fair_mode;
    int     beat_total;
    ch_id_t last_ch;
    logic   held;
    req_t   held_data;
    ch_id_t held_ch;

    cc_top #(
        .DEPTH        (DEPTH),
        .RC_DEFAULT   (RC_DEFAULT),
        .RT_DEFAULT   (RT_DEFAULT),
        .R_MIN        (R_MIN),
        .R_CAP        (R_CAP),
        .MARK_HOLDOFF (MARK_HOLDOFF),
        .SA_RECOVER   (SA_RECOVER),
        .TIME_THRESH  (TIME_THRESH),
        .PKT_THRESH   (PKT_THRESH),
        .F_STEPS      (F_STEPS),
        .R_AI         (R_AI),
        .R_HAI        (R_HAI)
    ) uut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req_data  (s_req_data),
        .ecn_valid   (ecn_valid),
        .ecn_mark    (ecn_mark),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_data  (m_req_data),
        .m_req_ch    (m_req_ch)
    );

    always #4 aclk = ~aclk;

    // ========================================================================
    // reference model
    // ========================================================================

    // a mark scales the interval by the table factor and clips at both ends
    function automatic rate_t expected_interval_after_mark(rate_t rc, int idx);
        longint scaled;
        if (rc > R_CAP) begin
            return rc;
        end
        scaled = (longint'(rc) * longint'(SA_TABLE[idx])) >> SG;
        if (scaled > (longint'(1) << RATE_W) - 1) begin
            scaled = (longint'(1) << RATE_W) - 1;
        end
        if (scaled < R_MIN) begin
            scaled = R_MIN;
        end
        return rate_t'(scaled);
    endfunction

    // the gate opens once the count passes the interval, and the beat lands one edge later
    function automatic rate_t expected_gap(rate_t interval);
        return rate_t'(interval + 2);
    endfunction

    task automatic check_req(input req_t actual, input req_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_ch(input ch_id_t actual, input ch_id_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_gap(input rate_t actual, input rate_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_ready(input logic [N_CH-1:0] actual, input logic [N_CH-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // during recovery a gap may only shrink and never undercuts the floor
    task automatic check_falling_gap(input rate_t gap, input rate_t prev);
        if (gap > prev || gap < expected_gap(rate_t'(R_MIN))) begin
            errors++;
            $display("Mismatch at %0t: recovery gap %0d after %0d", $time, gap, prev);
        end
    endtask

    // ========================================================================
    // compare process
    // ========================================================================

    always @(posedge aclk) begin : compare_beats
        rate_t gap;
        req_t  expected;
        cyc++;
        if (aresetn) begin
            if (held) begin
                if (!m_req_valid) begin
                    errors++;
                    $display("Error at %0t: valid dropped while a beat was held", $time);
                end
                check_req(m_req_data, held_data, "held data");
                check_ch(m_req_ch, held_ch, "held channel tag");
            end
            held      = m_req_valid && !m_req_ready;
            held_data = m_req_data;
            held_ch   = m_req_ch;
            if (m_req_valid && m_req_ready) begin
                if (exp_q[m_req_ch].size() == 0) begin
                    errors++;
                    $display("Error at %0t: beat on channel %0d with nothing pending",
                             $time, m_req_ch);
                end else begin
                    expected = exp_q[m_req_ch].pop_front();
                    check_req(m_req_data, expected, "descriptor");
                end
                if (fair_mode && beat_total > 0) begin
                    check_ch(m_req_ch, ~last_ch, "arbiter turn");
                end
                if (last_valid[m_req_ch]) begin
                    gap = rate_t'(cyc - last_cyc[m_req_ch]);
                    if (gap_mode[m_req_ch] == GAP_EXACT) begin
                        check_gap(gap, exp_gap[m_req_ch], "beat gap");
                    end else if (gap_mode[m_req_ch] == GAP_FALLING) begin
                        check_falling_gap(gap, prev_gap[m_req_ch]);
                        prev_gap[m_req_ch] = gap;
                    end
                end
                last_ch                = m_req_ch;
                last_cyc[m_req_ch]     = cyc;
                last_valid[m_req_ch]   = 1'b1;
                beat_cnt[m_req_ch]     = beat_cnt[m_req_ch] + 1;
                beat_total++;
            end
        end
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic wait_beats(input int ch, input int n);
        while (beat_cnt[ch] < n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic set_gap_check(input int ch, input int mode, input rate_t gap);
        gap_mode[ch]   = mode;
        exp_gap[ch]    = gap;
        last_valid[ch] = 1'b0;
        prev_gap[ch]   = '1;
    endtask

    task automatic pulse_mark(input int ch);
        ecn_valid[ch] = 1'b1;
        ecn_mark[ch]  = 1'b1;
        @(posedge aclk);
        #1;
        ecn_valid[ch] = 1'b0;
        ecn_mark[ch]  = 1'b0;
    endtask

    // data only changes after a channel's descriptor was taken
    task automatic push_desc(input logic [N_CH-1:0] mask, input int n);
        int              sent [N_CH];
        logic [N_CH-1:0] pend;
        logic [N_CH-1:0] taken;
        pend = (n > 0) ? mask : '0;
        for (int c = 0; c < N_CH; c++) begin
            sent[c]       = 0;
            s_req_data[c] = $random(seed);
        end
        while (pend != '0) begin
            s_req_valid = pend;
            @(posedge aclk);
            taken = pend & s_req_ready;
            #1;
            for (int c = 0; c < N_CH; c++) begin
                if (taken[c]) begin
                    exp_q[c].push_back(s_req_data[c]);
                    sent[c]++;
                    if (sent[c] == n) begin
                        pend[c] = 1'b0;
                    end else begin
                        s_req_data[c] = $random(seed);
                    end
                end
            end
        end
        s_req_valid = '0;
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        aclk        = 1'b0;
        aresetn     = 1'b0;
        s_req_valid = '0;
        s_req_data  = '0;
        ecn_valid   = '0;
        ecn_mark    = '0;
        m_req_ready = 1'b1;
        fair_mode   = 1'b0;
        beat_total  = 0;
        last_ch     = '0;
        held        = 1'b0;
        held_data   = '0;
        held_ch     = '0;
        for (int c = 0; c < N_CH; c++) begin
            beat_cnt[c] = 0;
            last_cyc[c] = 0;
            set_gap_check(c, GAP_OFF, '0);
        end
        repeat (16) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        check_ready(s_req_ready, {N_CH{1'b1}}, "input ready after reset");

        // default pacing on channel 0
        set_gap_check(0, GAP_EXACT, expected_gap(rate_t'(RC_DEFAULT)));
        push_desc(2'b01, 6);
        wait_beats(0, 6);

        // one mark right after a beat, then a second one inside the hold-off
        set_gap_check(0, GAP_OFF, '0);
        push_desc(2'b01, 4);
        wait_beats(0, 7);
        gap_mode[0] = GAP_EXACT;
        exp_gap[0]  = expected_gap(expected_interval_after_mark(rate_t'(RC_DEFAULT), 0));
        pulse_mark(0);
        idle(10);
        pulse_mark(0);
        wait_beats(0, 10);

        // unmarked feedback on both channels drives the packet timer
        set_gap_check(0, GAP_FALLING, '0);
        ecn_valid = '1;
        push_desc(2'b01, 8);
        wait_beats(0, 18);
        idle(SETTLE);
        ecn_valid = '0;

        // both channels at the floor rate share the bus in turn
        set_gap_check(0, GAP_EXACT, expected_gap(rate_t'(R_MIN)));
        set_gap_check(1, GAP_EXACT, expected_gap(rate_t'(R_MIN)));
        fair_mode = 1'b1;
        push_desc(2'b11, 6);
        wait_beats(0, 24);
        wait_beats(1, 6);
        fair_mode = 1'b0;

        // a stalled sink lets both FIFOs fill, then a randomly toggling one drains them
        set_gap_check(0, GAP_OFF, '0);
        set_gap_check(1, GAP_OFF, '0);
        m_req_ready = 1'b0;
        push_desc(2'b11, DEPTH);
        check_ready(s_req_ready, '0, "input ready with full FIFOs");
        idle(30);
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            m_req_ready = $random(seed);
            @(posedge aclk);
            #1;
        end
        m_req_ready = 1'b1;
        idle(5);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // every descriptor may take the slowest gap, plus reset, settling and the stall
    initial begin : watchdog
        int limit;
        limit = N_DESC * (expected_gap(expected_interval_after_mark(rate_t'(RC_DEFAULT), 0)) + 2)
                + SETTLE + 1000;
        repeat (limit) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles, errors %0d", limit, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== cc_top.sv ====
`timescale 1ns/10ps

module cc_top #(
    parameter int DEPTH        = 8,
    parameter int RC_DEFAULT   = 40,
    parameter int RT_DEFAULT   = 20,
    parameter int R_MIN        = 8,
    parameter int R_CAP        = 4096,
    parameter int MARK_HOLDOFF = 50,
    parameter int SA_RECOVER   = 200,
    parameter int TIME_THRESH  = 300,
    parameter int PKT_THRESH   = 16,
    parameter int F_STEPS      = 3,
    parameter int R_AI         = 4,
    parameter int R_HAI        = 8
) (
    input  logic                             aclk,
    input  logic                             aresetn,

    input  logic [cc_pkg::N_CH-1:0]          s_req_valid,
    output logic [cc_pkg::N_CH-1:0]          s_req_ready,
    input  cc_pkg::req_t [cc_pkg::N_CH-1:0]  s_req_data,

    input  logic [cc_pkg::N_CH-1:0]          ecn_valid,
    input  logic [cc_pkg::N_CH-1:0]          ecn_mark,

    output logic                             m_req_valid,
    input  logic                             m_req_ready,
    output cc_pkg::req_t                     m_req_data,
    output cc_pkg::ch_id_t                   m_req_ch
);
    import cc_pkg::*;

    logic [N_CH-1:0]         q_valid;
    logic [N_CH-1:0]         q_ready;
    req_t [N_CH-1:0]         q_data;

    // each channel paces itself from its own feedback stream
    for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
        cc_queue #(
            .DEPTH        (DEPTH),
            .RC_DEFAULT   (RC_DEFAULT),
            .RT_DEFAULT   (RT_DEFAULT),
            .R_MIN        (R_MIN),
            .R_CAP        (R_CAP),
            .MARK_HOLDOFF (MARK_HOLDOFF),
            .SA_RECOVER   (SA_RECOVER),
            .TIME_THRESH  (TIME_THRESH),
            .PKT_THRESH   (PKT_THRESH),
            .F_STEPS      (F_STEPS),
            .R_AI         (R_AI),
            .R_HAI        (R_HAI)
        ) u_queue (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .s_req_valid (s_req_valid[ch]),
            .s_req_ready (s_req_ready[ch]),
            .s_req_data  (s_req_data[ch]),
            .ecn_valid   (ecn_valid[ch]),
            .ecn_mark    (ecn_mark[ch]),
            .m_req_valid (q_valid[ch]),
            .m_req_ready (q_ready[ch]),
            .m_req_data  (q_data[ch])
        );
    end

    tx_arbiter u_arb (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (q_valid),
        .in_ready  (q_ready),
        .in_data   (q_data),
        .out_valid (m_req_valid),
        .out_ready (m_req_ready),
        .out_data  (m_req_data),
        .out_ch    (m_req_ch)
    );

endmodule

// ==== tx_arbiter.sv ====
`timescale 1ns/10ps

module tx_arbiter (
    input  logic                                aclk,
    input  logic                                aresetn,

    input  logic [cc_pkg::N_CH-1:0]             in_valid,
    output logic [cc_pkg::N_CH-1:0]             in_ready,
    input  cc_pkg::req_t [cc_pkg::N_CH-1:0]     in_data,

    output logic                                out_valid,
    input  logic                                out_ready,
    output cc_pkg::req_t                        out_data,
    output cc_pkg::ch_id_t                      out_ch
);
    import cc_pkg::*;

    ch_id_t last_ch;
    ch_id_t lock_ch;
    logic   locked;
    ch_id_t grant;
    ch_id_t cand;
    logic   found;

    // search starts just after the last granted channel and wraps around
    always_comb begin
        grant = last_ch;
        found = 1'b0;
        cand  = last_ch;
        for (int i = 1; i <= N_CH; i++) begin
            cand = ch_id_t'((last_ch + i) % N_CH);
            if (!found && in_valid[cand]) begin
                grant = cand;
                found = 1'b1;
            end
        end
        // a stalled beat keeps its grant until the sink takes it
        if (locked) begin
            grant = lock_ch;
        end
    end

    always_comb begin
        in_ready        = '0;
        in_ready[grant] = out_ready;
    end

    assign out_valid = in_valid[grant];
    assign out_data  = in_data[grant];
    assign out_ch    = grant;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            last_ch <= ch_id_t'(N_CH - 1);
            lock_ch <= '0;
            locked  <= 1'b0;
        end else if (out_valid && out_ready) begin
            last_ch <= grant;
            locked  <= 1'b0;
        end else if (out_valid) begin
            lock_ch <= grant;
            locked  <= 1'b1;
        end
    end

endmodule

// ==== cc_queue.sv ====
`timescale 1ns/10ps

module cc_queue #(
    parameter int DEPTH        = 8,
    parameter int RC_DEFAULT   = 40,
    parameter int RT_DEFAULT   = 20,
    parameter int R_MIN        = 8,
    parameter int R_CAP        = 4096,
    parameter int MARK_HOLDOFF = 50,
    parameter int SA_RECOVER   = 200,
    parameter int TIME_THRESH  = 300,
    parameter int PKT_THRESH   = 16,
    parameter int F_STEPS      = 3,
    parameter int R_AI         = 4,
    parameter int R_HAI        = 8
) (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          s_req_valid,
    output logic          s_req_ready,
    input  cc_pkg::req_t  s_req_data,

    input  logic          ecn_valid,
    input  logic          ecn_mark,

    output logic          m_req_valid,
    input  logic          m_req_ready,
    output cc_pkg::req_t  m_req_data
);
    import cc_pkg::*;

    logic          fifo_valid;
    logic          fifo_ready;
    req_t          fifo_data;
    rate_t         rc_interval;
    logic [RATE_W:0] pace_cnt;
    logic          pace_hold;
    logic          gate_open;

    req_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_req_valid),
        .s_ready (s_req_ready),
        .s_data  (s_req_data),
        .m_valid (fifo_valid),
        .m_ready (fifo_ready),
        .m_data  (fifo_data)
    );

    dcqcn_rate_ctrl #(
        .RC_DEFAULT   (RC_DEFAULT),
        .RT_DEFAULT   (RT_DEFAULT),
        .R_MIN        (R_MIN),
        .R_CAP        (R_CAP),
        .MARK_HOLDOFF (MARK_HOLDOFF),
        .SA_RECOVER   (SA_RECOVER),
        .TIME_THRESH  (TIME_THRESH),
        .PKT_THRESH   (PKT_THRESH),
        .F_STEPS      (F_STEPS),
        .R_AI         (R_AI),
        .R_HAI        (R_HAI)
    ) u_rate (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .ecn_valid   (ecn_valid),
        .ecn_mark    (ecn_mark),
        .rc_interval (rc_interval)
    );

    // once a beat is offered it stays offered, even if the rate slows meanwhile
    assign gate_open   = (pace_cnt > {1'b0, rc_interval}) || pace_hold;
    assign m_req_valid = fifo_valid && gate_open;
    assign fifo_ready  = m_req_ready && gate_open;
    assign m_req_data  = fifo_data;

    // the pacing count saturates so a long wait never wraps and closes the gate
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pace_cnt  <= '0;
            pace_hold <= 1'b0;
        end else if (m_req_valid && m_req_ready) begin
            pace_cnt  <= '0;
            pace_hold <= 1'b0;
        end else begin
            if (pace_cnt != '1) begin
                pace_cnt <= pace_cnt + 1'b1;
            end
            pace_hold <= m_req_valid;
        end
    end

endmodule

// ==== dcqcn_rate_ctrl.sv ====
`timescale 1ns/10ps

module dcqcn_rate_ctrl #(
    parameter int RC_DEFAULT   = 40,
    parameter int RT_DEFAULT   = 20,
    parameter int R_MIN        = 8,
    parameter int R_CAP        = 4096,
    parameter int MARK_HOLDOFF = 50,
    parameter int SA_RECOVER   = 200,
    parameter int TIME_THRESH  = 300,
    parameter int PKT_THRESH   = 16,
    parameter int F_STEPS      = 3,
    parameter int R_AI         = 4,
    parameter int R_HAI        = 8
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           ecn_valid,
    input  logic           ecn_mark,
    output cc_pkg::rate_t  rc_interval
);
    import cc_pkg::*;

    localparam int IDX_W   = $clog2(SA_MAX_IDX + 1);
    localparam int HOLD_W  = $clog2(MARK_HOLDOFF + 2);
    localparam int QUIET_W = $clog2(SA_RECOVER + 2);
    localparam int TIME_W  = $clog2(TIME_THRESH + 2);
    localparam int PKT_W   = $clog2(PKT_THRESH + 2);
    localparam int STEP_W  = $clog2(F_STEPS + 2);

    rate_t              rc;
    rate_t              rt;
    rate_t              rc_nxt;
    rate_t              rt_nxt;
    logic [IDX_W-1:0]   sa_idx;
    logic [HOLD_W-1:0]  holdoff_cnt;
    logic [QUIET_W-1:0] quiet_cnt;
    logic [TIME_W-1:0]  time_cnt;
    logic [PKT_W-1:0]   pkt_cnt;
    logic [STEP_W-1:0]  t_steps;
    logic [STEP_W-1:0]  p_steps;
    logic               inc_evt;
    logic               mark_hit;
    logic               time_exp;
    logic               pkt_exp;

    // the lowered target never drops below the minimum interval
    function automatic rate_t step_down(rate_t r, int step);
        if (r > R_MIN + step) begin
            return rate_t'(r - step);
        end
        return rate_t'(R_MIN);
    endfunction

    // a mark only counts once the previous reduction has had time to act
    assign mark_hit = ecn_valid && ecn_mark && (holdoff_cnt == '0);
    assign time_exp = (time_cnt > TIME_THRESH);
    assign pkt_exp  = (pkt_cnt > PKT_THRESH);

    assign rc_interval = rc;

    // ========================================================================
    // next current and target interval
    // ========================================================================

    always_comb begin
        rc_nxt = rc;
        rt_nxt = rt;
        if (mark_hit) begin
            rt_nxt = rc;
            if (rc <= R_CAP) begin
                rc_nxt = sa_scale(rc, SA_TABLE[sa_idx]);
            end
        end else if (inc_evt) begin
            if (t_steps >= F_STEPS && p_steps >= F_STEPS) begin
                rt_nxt = step_down(rt, R_HAI);
            end else if (t_steps >= F_STEPS || p_steps >= F_STEPS) begin
                rt_nxt = step_down(rt, R_AI);
            end
            // the current interval then moves halfway toward the new target
            rc_nxt = rate_t'(({1'b0, rt_nxt} + {1'b0, rc}) >> 1);
        end
        if (rc_nxt < R_MIN) begin
            rc_nxt = rate_t'(R_MIN);
        end
        if (rt_nxt < R_MIN) begin
            rt_nxt = rate_t'(R_MIN);
        end
    end

    // ========================================================================
    // timers and counters
    // ========================================================================

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rc          <= rate_t'(RC_DEFAULT);
            rt          <= rate_t'(RT_DEFAULT);
            sa_idx      <= '0;
            holdoff_cnt <= '0;
            quiet_cnt   <= '0;
            time_cnt    <= '0;
            pkt_cnt     <= '0;
            t_steps     <= '0;
            p_steps     <= '0;
            inc_evt     <= 1'b0;
        end else begin
            rc      <= rc_nxt;
            rt      <= rt_nxt;
            inc_evt <= 1'b0;

            if (holdoff_cnt != '0) begin
                holdoff_cnt <= holdoff_cnt - 1'b1;
            end

            // any mark, even one inside the hold-off, restarts the quiet period
            if (ecn_valid && ecn_mark) begin
                quiet_cnt <= '0;
            end else if (quiet_cnt > SA_RECOVER) begin
                quiet_cnt <= '0;
                if (sa_idx != IDX_W'(SA_MAX_IDX)) begin
                    sa_idx <= sa_idx + 1'b1;
                end
            end else begin
                quiet_cnt <= quiet_cnt + 1'b1;
            end

            if (mark_hit) begin
                holdoff_cnt <= HOLD_W'(MARK_HOLDOFF);
                if (sa_idx != '0) begin
                    sa_idx <= sa_idx - 1'b1;
                end
                time_cnt <= '0;
                pkt_cnt  <= '0;
                t_steps  <= '0;
                p_steps  <= '0;
            end else begin
                if (time_exp) begin
                    time_cnt <= '0;
                    if (t_steps < F_STEPS) begin
                        t_steps <= t_steps + 1'b1;
                    end
                end else begin
                    time_cnt <= time_cnt + 1'b1;
                end
                // every feedback beat stands for one received packet
                if (pkt_exp) begin
                    pkt_cnt <= '0;
                    if (p_steps < F_STEPS) begin
                        p_steps <= p_steps + 1'b1;
                    end
                end else if (ecn_valid) begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                end
                inc_evt <= time_exp || pkt_exp;
            end
        end
    end

endmodule

// ==== req_fifo.sv ====
`timescale 1ns/10ps

module req_fifo #(
    parameter int DEPTH = 8
) (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          s_valid,
    output logic          s_ready,
    input  cc_pkg::req_t  s_data,

    output logic          m_valid,
    input  logic          m_ready,
    output cc_pkg::req_t  m_data
);
    import cc_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    req_t          mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign s_ready = (count != CW'(DEPTH));
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    // storage is written only, the head is read combinationally
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // fill level only moves when exactly one side transfers
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== cc_pkg.sv ====
package cc_pkg;

    // ========================================================================
    // descriptor and rate widths
    // ========================================================================

    localparam int REQ_W = 32;

    // request descriptors are carried through the path without decoding
    typedef logic [REQ_W-1:0] req_t;

    localparam int RATE_W = 16;

    // cycles between two packets, so a larger value means a slower channel
    typedef logic [RATE_W-1:0] rate_t;

    localparam int N_CH = 2;

    typedef logic [$clog2(N_CH)-1:0] ch_id_t;

    // ========================================================================
    // DCQCN reduction factors
    // ========================================================================

    // fixed-point shift of the reduction factors
    localparam int SG = 7;

    localparam int SA_MAX_IDX = 28;

    // entry 0 doubles the interval, higher entries approach a gentle slowdown
    localparam logic [SG+1:0] SA_TABLE [0:SA_MAX_IDX] = '{
        9'd256, 9'd241, 9'd228, 9'd218, 9'd209, 9'd201, 9'd194, 9'd188,
        9'd182, 9'd178, 9'd173, 9'd170, 9'd166, 9'd163, 9'd161, 9'd158,
        9'd156, 9'd154, 9'd152, 9'd150, 9'd148, 9'd147, 9'd146, 9'd144,
        9'd143, 9'd142, 9'd141, 9'd140, 9'd139
    };

    // multiply an interval by a table factor and clip at the slowest rate
    function automatic rate_t sa_scale(rate_t interval, logic [SG+1:0] factor);
        logic [RATE_W+SG+1:0] prod;
        logic [RATE_W+1:0]    scaled;
        prod   = interval * factor;
        scaled = prod[RATE_W+SG+1:SG];
        if (scaled > {2'b00, {RATE_W{1'b1}}}) begin
            return '1;
        end
        return rate_t'(scaled);
    endfunction

endpackage
